/* dv/tb_clkgen.sv */
module tb_clkgen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release just after an edge, reset is synchronous
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* dv/tb_rv_alu_core.sv */
module tb_rv_alu_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RETIRE_DEPTH = 4;
    localparam int WAIT_LIMIT   = 200;

    logic        clk;
    logic        rst_n;
    logic        i_instr_valid;
    logic        o_instr_ready;
    logic [31:0] i_instr;
    logic        o_ret_valid;
    logic        i_ret_ready;
    logic [4:0]  o_ret_rd;
    logic [31:0] o_ret_data;
    logic        o_ret_illegal;

    // reference register state in program order
    logic [31:0] model_regs [32];
    // expected retire entries with the oldest at the front
    logic [4:0]  sb_rd   [$];
    logic [31:0] sb_data [$];
    logic        sb_ill  [$];
    int          sb_size;
    logic [4:0]  front_rd;
    logic [31:0] front_data;
    logic        front_ill;
    // retire handshake seen mid-cycle
    logic        consume;
    int          seed = 82;
    string       test_name;

    tb_clkgen #(.RESET_CYCLES(16)) u_clkgen (.clk(clk), .rst_n(rst_n));

    rv_alu_core #(.RETIRE_DEPTH(RETIRE_DEPTH)) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_instr       (i_instr),
        .o_ret_valid   (o_ret_valid),
        .i_ret_ready   (i_ret_ready),
        .o_ret_rd      (o_ret_rd),
        .o_ret_data    (o_ret_data),
        .o_ret_illegal (o_ret_illegal)
    );

    //////////////////////////////////////////////////
    // error exits
    //////////////////////////////////////////////////
    task automatic value_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::OPCODE_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::OPCODE_LUI};
    endfunction

    // random legal op-imm or lui
    // shift encodings keep a legal funct7
    function automatic logic [31:0] random_imm_instr();
        logic [31:0] r;
        logic [11:0] imm;
        r   = $random(seed);
        imm = r[31:20];
        if (r[14:12] == 3'd1)
            imm[11:5] = 7'h00;
        if (r[14:12] == 3'd5)
            imm[11:5] = r[30] ? 7'h20 : 7'h00;
        if (r[2:0] == 3'd0)
            return u_type(r[31:12], r[11:7]);
        return i_type(imm, r[19:15], r[14:12], r[11:7]);
    endfunction

    //////////////////////////////////////////////////
    // reference model and scoreboard
    //////////////////////////////////////////////////
    function automatic void update_front();
        sb_size    = sb_rd.size();
        front_rd   = (sb_size != 0) ? sb_rd[0]   : '0;
        front_data = (sb_size != 0) ? sb_data[0] : '0;
        front_ill  = (sb_size != 0) ? sb_ill[0]  : 1'b0;
    endfunction

    // rv32i alu semantics straight from the isa rules
    task automatic predict_retire(input logic [31:0] instr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ill;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        rd  = instr[11:7];
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        ill = 1'b0;
        res = '0;
        if (opc == rv_pkg::OPCODE_LUI)
            res = {instr[31:12], 12'h000};
        else if (opc == rv_pkg::OPCODE_OP || opc == rv_pkg::OPCODE_OP_IMM)
        begin
            if (opc == rv_pkg::OPCODE_OP)
                ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            else
            begin
                // i-type immediate sign extended from bit 31
                b = {{20{instr[31]}}, instr[31:20]};
                if (f3 == 3'd1)
                    ill = (f7 != 7'h00);
                if (f3 == 3'd5)
                    ill = (f7 != 7'h00 && f7 != 7'h20);
            end
            case (f3)
                3'd0:    res = (opc == rv_pkg::OPCODE_OP && f7[5]) ? a - b : a + b;
                3'd1:    res = a << b[4:0];
                3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3:    res = (a < b) ? 32'd1 : 32'd0;
                3'd4:    res = a ^ b;
                3'd6:    res = a | b;
                3'd7:    res = a & b;
                default:
                begin
                    if (f7[5])
                        res = $signed(a) >>> b[4:0];
                    else
                        res = a >> b[4:0];
                end
            endcase
        end
        else
            ill = 1'b1;
        // illegal writes nothing and reports rd zero
        if (ill)
            rd = '0;
        else if (rd != '0)
            model_regs[rd] = res;
        sb_rd.push_back(rd);
        sb_data.push_back(ill ? 32'd0 : res);
        sb_ill.push_back(ill);
        update_front();
    endtask

    always @(negedge clk)
        consume = rst_n && o_ret_valid && i_ret_ready;

    // drop the front entry on every consumed retire
    always @(posedge clk)
    begin
        if (consume && sb_size != 0)
        begin
            void'(sb_rd.pop_front());
            void'(sb_data.pop_front());
            void'(sb_ill.pop_front());
            update_front();
        end
    end

    //////////////////////////////////////////////////
    // retire checks
    //////////////////////////////////////////////////
    a_ret_expected: assert property (@(posedge clk) consume |-> sb_size != 0)
        else abort_run("retire entry with no instruction outstanding");
    a_ret_rd: assert property (@(posedge clk) consume |-> o_ret_rd == front_rd)
        else value_mismatch("rd", $sampled(front_rd), $sampled(o_ret_rd));
    a_ret_ill: assert property (@(posedge clk) consume |-> o_ret_illegal == front_ill)
        else value_mismatch("illegal", $sampled(front_ill), $sampled(o_ret_illegal));
    // data only carries meaning for legal entries
    a_ret_data: assert property (@(posedge clk) consume && !front_ill |-> o_ret_data == front_data)
        else value_mismatch("data", $sampled(front_data), $sampled(o_ret_data));

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////
    // called just after an edge and returns just after the accepting edge
    task automatic send_instr(input logic [31:0] instr);
        int waited;
        waited        = 0;
        i_instr       = instr;
        i_instr_valid = 1'b1;
        @(negedge clk);
        while (!o_instr_ready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("o_instr_ready stayed low, instruction never accepted");
            @(negedge clk);
        end
        predict_retire(instr);
        @(posedge clk);
        #1;
        i_instr_valid = 1'b0;
    endtask

    task automatic drain_queue();
        int waited;
        waited      = 0;
        i_ret_ready = 1'b1;
        while (sb_size != 0)
        begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("retire queue did not drain");
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [4:0]  prev_rd;
        logic [4:0]  older_rd;
        logic [4:0]  rd;
        logic [6:0]  f7;
        int          waited;
        int          accepted;
        int          lat;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_ret_ready   = 1'b1;
        consume       = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        update_front();

        test_name = "reset";
        waited    = 0;
        while (rst_n !== 1'b1)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("reset never released");
        end
        @(posedge clk);
        #1;
        assert (!o_ret_valid) else value_mismatch("o_ret_valid", 0, o_ret_valid);
        assert (o_instr_ready) else value_mismatch("o_instr_ready", 1, o_instr_ready);

        // lui + addi loads a random value in every register
        test_name = "imm_ops";
        for (int i = 1; i < 32; i++)
        begin
            r = $random(seed);
            send_instr(u_type(r[31:12], 5'(i)));
            send_instr(i_type(r[11:0], 5'(i), 3'd0, 5'(i)));
        end
        for (int i = 0; i < 60; i++)
            send_instr(random_imm_instr());

        // dependent chain on the last destination
        // rs2 from two back reads through the register-file bypass
        test_name = "fwd_chain";
        prev_rd   = 5'd1;
        older_rd  = 5'd2;
        for (int i = 0; i < 40; i++)
        begin
            r  = $random(seed);
            rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            f7 = ((r[14:12] == 3'd0 || r[14:12] == 3'd5) && r[30]) ? 7'h20 : 7'h00;
            send_instr(r_type(f7, r[5] ? prev_rd : older_rd, prev_rd, r[14:12], rd));
            older_rd = prev_rd;
            prev_rd  = rd;
        end

        test_name = "x0_illegal";
        send_instr(i_type(12'h7ff, 5'd3, 3'd0, 5'd0));
        send_instr(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));
        // load opcode, bad funct7, slli with upper bits set
        send_instr({20'h12345, 5'd7, 7'b0000011});
        send_instr(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd8));
        send_instr(i_type({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9));
        send_instr(r_type(7'h00, 5'd8, 5'd7, 3'd0, 5'd10));
        send_instr(r_type(7'h00, 5'd9, 5'd0, 3'd0, 5'd11));
        drain_queue();

        // queue plus both pipeline registers fill before the stall
        test_name   = "backpressure";
        i_ret_ready = 1'b0;
        accepted    = 0;
        r           = random_imm_instr();
        i_instr     = r;
        i_instr_valid = 1'b1;
        @(negedge clk);
        while (o_instr_ready)
        begin
            predict_retire(r);
            accepted++;
            if (accepted > WAIT_LIMIT)
                abort_run("o_instr_ready never dropped with i_ret_ready low");
            @(posedge clk);
            #1;
            r       = random_imm_instr();
            i_instr = r;
            @(negedge clk);
        end
        assert (accepted == RETIRE_DEPTH + 2)
            else value_mismatch("accepted before stall", RETIRE_DEPTH + 2, accepted);
        repeat (4)
        begin
            @(negedge clk);
            assert (!o_instr_ready)
                else value_mismatch("o_instr_ready held", 0, o_instr_ready);
        end
        @(posedge clk);
        #1;
        i_ret_ready = 1'b1;
        send_instr(r);
        drain_queue();

        test_name = "latency";
        send_instr(u_type(20'habcde, 5'd12));
        lat = 0;
        do
        begin
            @(negedge clk);
            lat++;
            if (lat > WAIT_LIMIT)
                abort_run("o_ret_valid never rose for a single instruction");
        end
        while (!o_ret_valid);
        assert (lat == 3) else value_mismatch("edges to o_ret_valid", 3, lat);
        @(posedge clk);
        #1;
        drain_queue();

        if (sb_size == 0 && !o_ret_valid)
        begin
            $display("sim passed");
            $finish;
        end
        else
            abort_run("entries left over at the end of the run");
    end

endmodule

/* rtl/rv_alu.sv */
module rv_alu (
    input  rv_pkg::alu_op_e i_op,
    input  rv_pkg::word_t   i_a,
    input  rv_pkg::word_t   i_b,
    output rv_pkg::word_t   o_y
);

    // shift amount from low five bits of b
    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb
    begin
        case (i_op)
            rv_pkg::ALU_ADD:
                o_y = i_a + i_b;
            rv_pkg::ALU_SUB:
                o_y = i_a - i_b;
            rv_pkg::ALU_SLL:
                o_y = i_a << shamt;
            // signed compare, result 0 or 1
            rv_pkg::ALU_SLT:
                o_y = ($signed(i_a) < $signed(i_b)) ? 32'd1 : 32'd0;
            // unsigned compare
            rv_pkg::ALU_SLTU:
                o_y = (i_a < i_b) ? 32'd1 : 32'd0;
            rv_pkg::ALU_XOR:
                o_y = i_a ^ i_b;
            rv_pkg::ALU_SRL:
                o_y = i_a >> shamt;
            // arithmetic shift keeps the sign bit
            rv_pkg::ALU_SRA:
                o_y = rv_pkg::word_t'($signed(i_a) >>> shamt);
            rv_pkg::ALU_OR:
                o_y = i_a | i_b;
            rv_pkg::ALU_AND:
                o_y = i_a & i_b;
            // lui
            rv_pkg::ALU_PASS_B:
                o_y = i_b;
            default:
                o_y = '0;
        endcase
    end

endmodule

/* rtl/rv_alu_core.sv */
module rv_alu_core #(
    parameter int RETIRE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_instr_valid,
    output logic              o_instr_ready,
    input  rv_pkg::word_t     i_instr,
    output logic              o_ret_valid,
    input  logic              i_ret_ready,
    output rv_pkg::reg_addr_t o_ret_rd,
    output rv_pkg::word_t     o_ret_data,
    output logic              o_ret_illegal
);

    //////////////////////////////////////////////////
    // decode outputs
    //////////////////////////////////////////////////
    rv_pkg::alu_op_e   dec_alu_op;
    logic              dec_use_imm;
    rv_pkg::word_t     dec_imm;
    rv_pkg::reg_addr_t dec_rs1;
    rv_pkg::reg_addr_t dec_rs2;
    rv_pkg::reg_addr_t dec_rd;
    logic              dec_wen;
    logic              dec_illegal;

    // register file reads
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    // writeback / push side
    logic              wb_valid;
    logic              wb_wen;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              wb_illegal;

    // queue full doubles as pipeline stall
    logic              ret_full;
    logic              issue;

    assign o_instr_ready = !ret_full;
    assign issue         = i_instr_valid && !ret_full;

    rv_decoder u_decoder (
        .i_instr   (i_instr),
        .o_alu_op  (dec_alu_op),
        .o_use_imm (dec_use_imm),
        .o_imm     (dec_imm),
        .o_rs1     (dec_rs1),
        .o_rs2     (dec_rs2),
        .o_rd      (dec_rd),
        .o_wen     (dec_wen),
        .o_illegal (dec_illegal)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wen      (wb_wen),
        .i_rd       (wb_rd),
        .i_wd       (wb_data)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_stall      (ret_full),
        .i_issue      (issue),
        .i_alu_op     (dec_alu_op),
        .i_use_imm    (dec_use_imm),
        .i_imm        (dec_imm),
        .i_rs1        (dec_rs1),
        .i_rs2        (dec_rs2),
        .i_rd         (dec_rd),
        .i_wen        (dec_wen),
        .i_illegal    (dec_illegal),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_wb_valid   (wb_valid),
        .o_wb_wen     (wb_wen),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data),
        .o_wb_illegal (wb_illegal)
    );

    rv_retire_fifo #(
        .RETIRE_DEPTH (RETIRE_DEPTH)
    ) u_retire_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_push    (wb_valid),
        .i_rd      (wb_rd),
        .i_data    (wb_data),
        .i_illegal (wb_illegal),
        .o_full    (ret_full),
        .o_valid   (o_ret_valid),
        .i_ready   (i_ret_ready),
        .o_rd      (o_ret_rd),
        .o_data    (o_ret_data),
        .o_illegal (o_ret_illegal)
    );

endmodule

/* rtl/rv_decoder.sv */
module rv_decoder (
    input  rv_pkg::word_t     i_instr,
    output rv_pkg::alu_op_e   o_alu_op,
    output logic              o_use_imm,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::reg_addr_t o_rs1,
    output rv_pkg::reg_addr_t o_rs2,
    output rv_pkg::reg_addr_t o_rd,
    output logic              o_wen,
    output logic              o_illegal
);

    // instruction fields
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rd_field;
    logic              legal;

    assign opcode   = i_instr[6:0];
    assign rd_field = i_instr[11:7];
    assign funct3   = i_instr[14:12];
    assign funct7   = i_instr[31:25];

    // source fields go out raw, unused ones are harmless
    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];

    //////////////////////////////////////////////////
    // opcode and funct decode
    //////////////////////////////////////////////////
    always_comb
    begin
        o_alu_op  = rv_pkg::ALU_ADD;
        o_use_imm = 1'b0;
        o_imm     = '0;
        legal     = 1'b1;
        case (opcode)
            rv_pkg::OPCODE_OP:
            begin
                case (funct3)
                    3'b000:  o_alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  o_alu_op = rv_pkg::ALU_SLL;
                    3'b010:  o_alu_op = rv_pkg::ALU_SLT;
                    3'b011:  o_alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  o_alu_op = rv_pkg::ALU_XOR;
                    3'b101:  o_alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  o_alu_op = rv_pkg::ALU_OR;
                    default: o_alu_op = rv_pkg::ALU_AND;
                endcase
                // funct7 0x20 only valid for sub and sra
                if (funct7 == 7'b0100000)
                begin
                    if (funct3 != 3'b000 && funct3 != 3'b101)
                        legal = 1'b0;
                end
                else if (funct7 != 7'b0000000)
                begin
                    legal = 1'b0;
                end
            end
            rv_pkg::OPCODE_OP_IMM:
            begin
                // i-type, sign extended from bit 31
                o_use_imm = 1'b1;
                o_imm     = {{20{i_instr[31]}}, i_instr[31:20]};
                case (funct3)
                    3'b000:  o_alu_op = rv_pkg::ALU_ADD;
                    3'b010:  o_alu_op = rv_pkg::ALU_SLT;
                    3'b011:  o_alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  o_alu_op = rv_pkg::ALU_XOR;
                    3'b110:  o_alu_op = rv_pkg::ALU_OR;
                    3'b111:  o_alu_op = rv_pkg::ALU_AND;
                    3'b001:
                    begin
                        // slli, upper bits must be zero
                        o_alu_op = rv_pkg::ALU_SLL;
                        legal    = (funct7 == 7'b0000000);
                    end
                    default:
                    begin
                        // srli / srai share funct3
                        o_alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        legal    = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            rv_pkg::OPCODE_LUI:
            begin
                // u-type, low 12 bits zero
                o_alu_op  = rv_pkg::ALU_PASS_B;
                o_use_imm = 1'b1;
                o_imm     = {i_instr[31:12], 12'b0};
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    // illegal or x0 destination means no write and rd zero
    assign o_illegal = ~legal;
    assign o_wen     = legal && (rd_field != '0);
    assign o_rd      = legal ? rd_field : '0;

endmodule

/* rtl/rv_execute.sv */
module rv_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_stall,
    input  logic              i_issue,
    input  rv_pkg::alu_op_e   i_alu_op,
    input  logic              i_use_imm,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  rv_pkg::reg_addr_t i_rd,
    input  logic              i_wen,
    input  logic              i_illegal,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output logic              o_wb_valid,
    output logic              o_wb_wen,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data,
    output logic              o_wb_illegal
);

    // decode/execute register
    logic              de_valid;
    rv_pkg::alu_op_e   de_alu_op;
    logic              de_use_imm;
    rv_pkg::word_t     de_imm;
    rv_pkg::reg_addr_t de_rs1;
    rv_pkg::reg_addr_t de_rs2;
    rv_pkg::reg_addr_t de_rd;
    logic              de_wen;
    logic              de_illegal;
    rv_pkg::word_t     de_rs1_data;
    rv_pkg::word_t     de_rs2_data;

    // execute/writeback register
    logic              wb_valid;
    logic              wb_wen;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              wb_illegal;

    // forwarding and alu
    logic              fwd_a;
    logic              fwd_b;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     rs2_val;
    rv_pkg::word_t     op_b;
    rv_pkg::word_t     alu_y;

    //////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////

    // wb_wen is never set for x0, so no x0 check needed
    assign fwd_a = wb_valid && wb_wen && (wb_rd == de_rs1);
    assign fwd_b = wb_valid && wb_wen && (wb_rd == de_rs2);

    assign op_a    = fwd_a ? wb_data : de_rs1_data;
    assign rs2_val = fwd_b ? wb_data : de_rs2_data;
    // immediate replaces rs2 for op_imm and lui
    assign op_b    = de_use_imm ? de_imm : rs2_val;

    rv_alu u_alu (
        .i_op (de_alu_op),
        .i_a  (op_a),
        .i_b  (op_b),
        .o_y  (alu_y)
    );

    //////////////////////////////////////////////////
    // pipeline registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            de_valid    <= 1'b0;
            de_alu_op   <= rv_pkg::ALU_ADD;
            de_use_imm  <= 1'b0;
            de_imm      <= '0;
            de_rs1      <= '0;
            de_rs2      <= '0;
            de_rd       <= '0;
            de_wen      <= 1'b0;
            de_illegal  <= 1'b0;
            de_rs1_data <= '0;
            de_rs2_data <= '0;
            wb_valid    <= 1'b0;
            wb_wen      <= 1'b0;
            wb_rd       <= '0;
            wb_data     <= '0;
            wb_illegal  <= 1'b0;
        end
        // queue full, everything holds
        else if (!i_stall)
        begin
            de_valid <= i_issue;
            // payload only moves on acceptance
            if (i_issue)
            begin
                de_alu_op   <= i_alu_op;
                de_use_imm  <= i_use_imm;
                de_imm      <= i_imm;
                de_rs1      <= i_rs1;
                de_rs2      <= i_rs2;
                de_rd       <= i_rd;
                de_wen      <= i_wen;
                de_illegal  <= i_illegal;
                de_rs1_data <= i_rs1_data;
                de_rs2_data <= i_rs2_data;
            end
            wb_valid   <= de_valid;
            wb_wen     <= de_valid && de_wen;
            wb_rd      <= de_rd;
            // illegal result zeroed, value has no meaning
            wb_data    <= de_illegal ? '0 : alu_y;
            wb_illegal <= de_illegal;
        end
    end

    // write and push fire once, never while held
    assign o_wb_valid   = wb_valid && !i_stall;
    assign o_wb_wen     = wb_valid && wb_wen && !i_stall;
    assign o_wb_rd      = wb_rd;
    assign o_wb_data    = wb_data;
    assign o_wb_illegal = wb_illegal;

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // data path width
    parameter int XLEN = 32;

    // architectural register count, x0 included
    parameter int NUM_REGS = 32;

    // one register or result value
    typedef logic [XLEN-1:0] word_t;

    // register index, wide enough for NUM_REGS
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // major opcodes
    //////////////////////////////////////////////////

    // register-register alu group
    parameter logic [6:0] OPCODE_OP     = 7'b0110011;
    // register-immediate alu group
    parameter logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    // load upper immediate
    parameter logic [6:0] OPCODE_LUI    = 7'b0110111;

    //////////////////////////////////////////////////
    // alu operations
    //////////////////////////////////////////////////

    // pass_b hands operand b straight through, used by lui
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

/* rtl/rv_regfile.sv */
module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data,
    input  logic              i_wen,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_wd
);

    // architectural state
    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // write port, x0 never stored
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_wen && (i_rd != '0))
        begin
            regs[i_rd] <= i_wd;
        end
    end

    // read ports
    // x0 reads zero, same-cycle write bypasses the array
    assign o_rs1_data = (i_rs1 == '0)                  ? '0   :
                        (i_wen && (i_rd == i_rs1))     ? i_wd :
                                                         regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0)                  ? '0   :
                        (i_wen && (i_rd == i_rs2))     ? i_wd :
                                                         regs[i_rs2];

endmodule

/* rtl/rv_retire_fifo.sv */
module rv_retire_fifo #(
    parameter int RETIRE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_push,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_data,
    input  logic              i_illegal,
    output logic              o_full,
    output logic              o_valid,
    input  logic              i_ready,
    output rv_pkg::reg_addr_t o_rd,
    output rv_pkg::word_t     o_data,
    output logic              o_illegal
);

    localparam int PTR_W = $clog2(RETIRE_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = RETIRE_DEPTH[PTR_W:0];

    // entry storage
    rv_pkg::reg_addr_t rd_mem   [RETIRE_DEPTH];
    rv_pkg::word_t     data_mem [RETIRE_DEPTH];
    logic              ill_mem  [RETIRE_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    // push refused while full, even with a pop in the same cycle
    assign do_push = i_push && !o_full;
    assign do_pop  = o_valid && i_ready;

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            rd_mem[wr_ptr]   <= i_rd;
            data_mem[wr_ptr] <= i_data;
            ill_mem[wr_ptr]  <= i_illegal;
        end
    end

    // pointers wrap since depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // head of queue
    assign o_full    = (count == DEPTH_CNT);
    assign o_valid   = (count != '0);
    assign o_rd      = rd_mem[rd_ptr];
    assign o_data    = data_mem[rd_ptr];
    assign o_illegal = ill_mem[rd_ptr];

endmodule

/* rv_alu_core.f */
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_execute.sv
rtl/rv_retire_fifo.sv
rtl/rv_alu_core.sv
dv/tb_clkgen.sv
dv/tb_rv_alu_core.sv
